/* hdl/rv32_isa_pkg.sv */
`default_nettype none

package rv32_isa_pkg;

    // basic word types
    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    // instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // major opcodes handled by the core
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    // alu funct3 codes, shared by register and immediate forms
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // branch funct3 codes
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // funct7 that turns add into sub and srl into sra
    localparam funct7_t F7_ALT = 7'b0100000;

    // byte distance between sequential instructions
    localparam word_t PC_STEP = 32'd4;

endpackage

`default_nettype wire

/* hdl/core_ctrl_pkg.sv */
`default_nettype none

package core_ctrl_pkg;

    // multicycle FSM states
    typedef enum logic [3:0] {
        S_FETCH      = 4'd0,
        S_DECODE     = 4'd1,
        S_MEMADR     = 4'd2,
        S_MEMREAD    = 4'd3,
        S_MEMWB      = 4'd4,
        S_EXECUTE_RI = 4'd5,
        S_ALUWB      = 4'd6,
        S_MEMWRITE   = 4'd7,
        S_BRANCH     = 4'd8,
        S_JALR       = 4'd9
    } core_state_t;

    // alu operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // alu operand a source
    typedef enum logic [1:0] {SRC_A_PC, SRC_A_REG, SRC_A_OLD_PC, SRC_A_ZERO} src_a_t;

    // alu operand b source
    typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM, SRC_B_STEP, SRC_B_ZERO} src_b_t;

    // register file write data source
    typedef enum logic [1:0] {
        RESULT_ALU,
        RESULT_MEM_DATA,
        RESULT_ALU_LAST,
        RESULT_PC_NEXT
    } result_src_t;

    // next pc source
    typedef enum logic {PC_SRC_NEXT, PC_SRC_JUMP} pc_src_t;

    // memory address source
    typedef enum logic {ADDR_SRC_PC, ADDR_SRC_ALU_LAST} addr_src_t;

endpackage

`default_nettype wire

/* hdl/core_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface core_ctrl_if
    import rv32_isa_pkg::*, core_ctrl_pkg::*;
();

    // register enables, set by the FSM
    logic ir_write;
    logic pc_old_ena;
    logic pc_next_ena;
    logic pc_ena;
    logic alu_last_ena;
    logic mem_data_ena;
    logic reg_write;

    // operation and mux selects
    alu_op_t     alu_op;
    src_a_t      src_a;
    src_b_t      src_b;
    result_src_t result_src;
    pc_src_t     pc_src;
    addr_src_t   addr_src;

    // decoded fields and compare flags back from the datapath
    opcode_t op;
    funct3_t funct3;
    funct7_t funct7;
    logic    alu_equal;
    // bit 0 of the alu result, meaningful for slt and sltu
    logic    alu_lt;

    modport ctrl (
        output ir_write, pc_old_ena, pc_next_ena, pc_ena, alu_last_ena, mem_data_ena,
        output reg_write, alu_op, src_a, src_b, result_src, pc_src, addr_src,
        input  op, funct3, funct7, alu_equal, alu_lt
    );

    modport dp (
        input  ir_write, pc_old_ena, pc_next_ena, pc_ena, alu_last_ena, mem_data_ena,
        input  reg_write, alu_op, src_a, src_b, result_src, pc_src, addr_src,
        output op, funct3, funct7, alu_equal, alu_lt
    );

endinterface

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
    import rv32_isa_pkg::*, core_ctrl_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result,
    output logic    equal
);

    logic [4:0] shamt;

    // shifts only look at the low five bits
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    // compare flag for beq and bne, whatever op is selected
    assign equal = (a == b);

endmodule

`default_nettype wire

/* hdl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file
    import rv32_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rd_addr0,
    input  reg_addr_t rd_addr1,
    input  logic      wr_ena,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output word_t     rd_data0,
    output word_t     rd_data1
);

    word_t regs [32];

    // x0 is never written, so it stays at its reset zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ena && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // two async read ports
    assign rd_data0 = regs[rd_addr0];
    assign rd_data1 = regs[rd_addr1];

endmodule

`default_nettype wire

/* hdl/core_control.sv */
`timescale 1ns/1ps
`default_nettype none

module core_control
    import rv32_isa_pkg::*, core_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    core_ctrl_if.ctrl ctrl,
    output logic      mem_wr_ena,
    output logic      instruction_done,
    output word_t     instructions_completed
);

    core_state_t state;
    core_state_t state_next;
    alu_op_t     ri_alu_op;
    logic        is_jump;
    logic        branch_unsigned;
    logic        branch_take;

    // state register
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = S_FETCH;
        case (state)
            S_FETCH: state_next = S_DECODE;
            S_DECODE: begin
                case (ctrl.op)
                    OPC_LOAD, OPC_STORE: state_next = S_MEMADR;
                    OPC_OP, OPC_OP_IMM:  state_next = S_EXECUTE_RI;
                    OPC_BRANCH:          state_next = S_BRANCH;
                    OPC_JAL:             state_next = S_ALUWB;
                    OPC_JALR:            state_next = S_JALR;
                    // unknown opcode retires with no effect
                    default:             state_next = S_FETCH;
                endcase
            end
            S_MEMADR: state_next = (ctrl.op == OPC_LOAD) ? S_MEMREAD : S_MEMWRITE;
            S_MEMREAD: state_next = S_MEMWB;
            S_EXECUTE_RI, S_JALR: state_next = S_ALUWB;
            default: state_next = S_FETCH;
        endcase
    end

    // every instruction ends in the cycle that returns to fetch
    assign instruction_done = (state != S_FETCH) && (state_next == S_FETCH);

    always_ff @(posedge clk) begin
        if (rst) begin
            instructions_completed <= '0;
        end else if (instruction_done) begin
            instructions_completed <= instructions_completed + word_t'(1);
        end
    end

    // alu op for register and immediate forms
    always_comb begin
        case (ctrl.funct3)
            F3_ADD_SUB: begin
                // only the register form has sub
                if (ctrl.op == OPC_OP && ctrl.funct7 == F7_ALT) begin
                    ri_alu_op = ALU_SUB;
                end else begin
                    ri_alu_op = ALU_ADD;
                end
            end
            F3_SLL:     ri_alu_op = ALU_SLL;
            F3_SLT:     ri_alu_op = ALU_SLT;
            F3_SLTU:    ri_alu_op = ALU_SLTU;
            F3_XOR:     ri_alu_op = ALU_XOR;
            F3_SRL_SRA: ri_alu_op = (ctrl.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            F3_OR:      ri_alu_op = ALU_OR;
            default:    ri_alu_op = ALU_AND;
        endcase
    end

    // branch condition from the alu flags
    always_comb begin
        branch_unsigned = (ctrl.funct3 == F3_BLTU) || (ctrl.funct3 == F3_BGEU);
        case (ctrl.funct3)
            F3_BEQ:  branch_take = ctrl.alu_equal;
            F3_BNE:  branch_take = !ctrl.alu_equal;
            F3_BLT:  branch_take = ctrl.alu_lt;
            F3_BGE:  branch_take = !ctrl.alu_lt;
            F3_BLTU: branch_take = ctrl.alu_lt;
            F3_BGEU: branch_take = !ctrl.alu_lt;
            default: branch_take = 1'b0;
        endcase
    end

    assign is_jump = (ctrl.op == OPC_JAL) || (ctrl.op == OPC_JALR);

    // control word per state
    always_comb begin
        ctrl.ir_write     = 1'b0;
        ctrl.pc_old_ena   = 1'b0;
        ctrl.pc_next_ena  = 1'b0;
        ctrl.pc_ena       = 1'b0;
        ctrl.alu_last_ena = 1'b0;
        ctrl.mem_data_ena = 1'b0;
        ctrl.reg_write    = 1'b0;
        mem_wr_ena        = 1'b0;
        ctrl.alu_op       = ALU_ADD;
        ctrl.src_a        = SRC_A_PC;
        ctrl.src_b        = SRC_B_STEP;
        ctrl.result_src   = RESULT_ALU_LAST;
        ctrl.pc_src       = PC_SRC_NEXT;
        ctrl.addr_src     = ADDR_SRC_PC;
        case (state)
            S_FETCH: begin
                // latch instruction, save pc and pc + 4
                ctrl.ir_write    = 1'b1;
                ctrl.pc_old_ena  = 1'b1;
                ctrl.pc_next_ena = 1'b1;
            end
            S_DECODE: begin
                // branch and jal target, old pc + imm
                ctrl.src_a        = SRC_A_OLD_PC;
                ctrl.src_b        = SRC_B_IMM;
                ctrl.alu_last_ena = 1'b1;
            end
            S_MEMADR, S_JALR: begin
                // rs1 + imm, load/store address or jalr target
                ctrl.src_a        = SRC_A_REG;
                ctrl.src_b        = SRC_B_IMM;
                ctrl.alu_last_ena = 1'b1;
            end
            S_MEMREAD: begin
                ctrl.addr_src     = ADDR_SRC_ALU_LAST;
                ctrl.mem_data_ena = 1'b1;
            end
            S_MEMWB: begin
                ctrl.result_src = RESULT_MEM_DATA;
                ctrl.reg_write  = 1'b1;
                ctrl.pc_ena     = 1'b1;
            end
            S_MEMWRITE: begin
                ctrl.addr_src = ADDR_SRC_ALU_LAST;
                mem_wr_ena    = 1'b1;
                ctrl.pc_ena   = 1'b1;
            end
            S_EXECUTE_RI: begin
                ctrl.alu_op       = ri_alu_op;
                ctrl.src_a        = SRC_A_REG;
                ctrl.src_b        = (ctrl.op == OPC_OP_IMM) ? SRC_B_IMM : SRC_B_REG;
                ctrl.alu_last_ena = 1'b1;
            end
            S_ALUWB: begin
                ctrl.reg_write = 1'b1;
                ctrl.pc_ena    = 1'b1;
                // jumps link pc + 4 and take the saved target
                if (is_jump) begin
                    ctrl.result_src = RESULT_PC_NEXT;
                    ctrl.pc_src     = PC_SRC_JUMP;
                end
            end
            S_BRANCH: begin
                ctrl.alu_op = branch_unsigned ? ALU_SLTU : ALU_SLT;
                ctrl.src_a  = SRC_A_REG;
                ctrl.src_b  = SRC_B_REG;
                ctrl.pc_ena = 1'b1;
                ctrl.pc_src = branch_take ? PC_SRC_JUMP : PC_SRC_NEXT;
            end
            default: begin
                ctrl.pc_src = PC_SRC_NEXT;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/core_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module core_datapath
    import rv32_isa_pkg::*, core_ctrl_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      rst,
    input  word_t     mem_rd_data,
    core_ctrl_if.dp   dp,
    output word_t     mem_addr,
    output word_t     mem_wr_data,
    output word_t     pc,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output word_t     rf_wr_data,
    output logic      rf_wr_ena,
    input  word_t     rs1_data,
    input  word_t     rs2_data
);

    instr_t ir;
    word_t  pc_old;
    word_t  pc_next_instr;
    word_t  pc_next;
    word_t  alu_last;
    word_t  mem_data;
    word_t  reg_a;
    word_t  reg_b;
    word_t  imm;
    word_t  alu_a;
    word_t  alu_b;
    word_t  alu_result;

    // instruction fields
    assign dp.op     = ir[6:0];
    assign rd        = ir[11:7];
    assign dp.funct3 = ir[14:12];
    assign rs1       = ir[19:15];
    assign rs2       = ir[24:20];
    assign dp.funct7 = ir[31:25];

    // immediate by format
    always_comb begin
        case (dp.op)
            OPC_STORE:  imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            OPC_BRANCH: imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            OPC_JAL:    imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            // i format for op-imm, load and jalr
            default:    imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

    // program counter starts at RESET_PC
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (dp.pc_ena) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (dp.ir_write) begin
            ir <= mem_rd_data;
        end
        if (dp.pc_old_ena) begin
            pc_old <= pc;
        end
        if (dp.pc_next_ena) begin
            pc_next_instr <= alu_result;
        end
        if (dp.alu_last_ena) begin
            alu_last <= alu_result;
        end
        if (dp.mem_data_ena) begin
            mem_data <= mem_rd_data;
        end
        // operand registers follow the register file every cycle
        reg_a <= rs1_data;
        reg_b <= rs2_data;
    end

    // operand muxes
    always_comb begin
        case (dp.src_a)
            SRC_A_PC:     alu_a = pc;
            SRC_A_REG:    alu_a = reg_a;
            SRC_A_OLD_PC: alu_a = pc_old;
            default:      alu_a = '0;
        endcase
        case (dp.src_b)
            SRC_B_REG:  alu_b = reg_b;
            SRC_B_IMM:  alu_b = imm;
            SRC_B_STEP: alu_b = PC_STEP;
            default:    alu_b = '0;
        endcase
    end

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dp.alu_op),
        .result (alu_result),
        .equal  (dp.alu_equal)
    );

    assign dp.alu_lt = alu_result[0];

    // write back data
    always_comb begin
        case (dp.result_src)
            RESULT_ALU:      rf_wr_data = alu_result;
            RESULT_MEM_DATA: rf_wr_data = mem_data;
            RESULT_ALU_LAST: rf_wr_data = alu_last;
            default:         rf_wr_data = pc_next_instr;
        endcase
    end

    assign rf_wr_ena   = dp.reg_write;
    assign pc_next     = (dp.pc_src == PC_SRC_JUMP) ? alu_last : pc_next_instr;
    assign mem_addr    = (dp.addr_src == ADDR_SRC_ALU_LAST) ? alu_last : pc;
    // stores always take rs2
    assign mem_wr_data = reg_b;

endmodule

`default_nettype wire

/* hdl/rv32_mini_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_mini_core
    import rv32_isa_pkg::*, core_ctrl_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst,
    input  word_t mem_rd_data,
    output word_t mem_addr,
    output word_t mem_wr_data,
    output logic  mem_wr_ena,
    output word_t pc,
    output word_t instructions_completed,
    output logic  instruction_done
);

    // register file side of the datapath
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     rf_wr_data;
    logic      rf_wr_ena;

    core_ctrl_if u_ctrl_if ();

    core_control u_control (
        .clk                    (clk),
        .rst                    (rst),
        .ctrl                   (u_ctrl_if.ctrl),
        .mem_wr_ena             (mem_wr_ena),
        .instruction_done       (instruction_done),
        .instructions_completed (instructions_completed)
    );

    core_datapath #(
        .RESET_PC (RESET_PC)
    ) u_datapath (
        .clk         (clk),
        .rst         (rst),
        .mem_rd_data (mem_rd_data),
        .dp          (u_ctrl_if.dp),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .pc          (pc),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .rf_wr_data  (rf_wr_data),
        .rf_wr_ena   (rf_wr_ena),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data)
    );

    register_file u_register_file (
        .clk      (clk),
        .rst      (rst),
        .rd_addr0 (rs1),
        .rd_addr1 (rs2),
        .wr_ena   (rf_wr_ena),
        .wr_addr  (rd),
        .wr_data  (rf_wr_data),
        .rd_data0 (rs1_data),
        .rd_data1 (rs2_data)
    );

endmodule

`default_nettype wire

/* verif/core_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module core_properties
    import rv32_isa_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  instruction_done,
    input logic  mem_wr_ena,
    input word_t mem_addr,
    input word_t pc
);

    // every instruction starts with a fetch, so done can never repeat
    done_single_cycle: assert property (
        @(posedge clk) disable iff (rst) instruction_done |=> !instruction_done
    ) else $error("instruction_done high in two consecutive cycles");

    // only word stores exist
    store_aligned: assert property (
        @(posedge clk) disable iff (rst) mem_wr_ena |-> (mem_addr[1:0] == 2'b00)
    ) else $error("store to a misaligned address %h", mem_addr);

    pc_aligned: assert property (
        @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
    ) else $error("pc not word aligned: %h", pc);

    // first cycle out of reset is a plain fetch
    reset_quiet: assert property (
        @(posedge clk) $fell(rst) |-> (!instruction_done && !mem_wr_ena)
    ) else $error("retire or store in the first cycle after reset");

endmodule

// attach to every core instance
bind rv32_mini_core core_properties u_core_properties (
    .clk              (clk),
    .rst              (rst),
    .instruction_done (instruction_done),
    .mem_wr_ena       (mem_wr_ena),
    .mem_addr         (mem_addr),
    .pc               (pc)
);

`default_nettype wire

/* verif/tb_rv32_mini_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv32_mini_core
    import rv32_isa_pkg::*;
();

    // funct3 values not named in the package
    localparam funct3_t F3_WORD = 3'b010;
    localparam funct3_t F3_JALR = 3'b000;

    // register names used by the program
    localparam reg_addr_t X0  = 5'd0;
    localparam reg_addr_t X1  = 5'd1;
    localparam reg_addr_t X2  = 5'd2;
    localparam reg_addr_t X3  = 5'd3;
    localparam reg_addr_t X4  = 5'd4;
    localparam reg_addr_t X5  = 5'd5;
    localparam reg_addr_t X6  = 5'd6;
    localparam reg_addr_t X7  = 5'd7;
    localparam reg_addr_t X8  = 5'd8;
    localparam reg_addr_t X9  = 5'd9;
    localparam reg_addr_t X10 = 5'd10;

    logic  clk;
    logic  rst;
    word_t mem_rd_data;
    word_t mem_addr;
    word_t mem_wr_data;
    logic  mem_wr_ena;
    word_t pc;
    word_t instructions_completed;
    logic  instruction_done;

    // memory seen by the DUT, its initial image, and the model's copy
    word_t mem [256];
    word_t image [256];
    word_t model_mem [256];
    word_t model_regs [32];
    word_t model_pc;

    word_t       halt_addr;
    int          emit_idx;
    int          prog_len = 0;
    logic [11:0] st_off;
    integer      seed;
    int          n_checks = 0;
    int          n_errors = 0;
    logic        checks_done = 1'b0;

    rv32_mini_core #(
        .RESET_PC (32'd0)
    ) u_dut (
        .clk                    (clk),
        .rst                    (rst),
        .mem_rd_data            (mem_rd_data),
        .mem_addr               (mem_addr),
        .mem_wr_data            (mem_wr_data),
        .mem_wr_ena             (mem_wr_ena),
        .pc                     (pc),
        .instructions_completed (instructions_completed),
        .instruction_done       (instruction_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // word addressed, combinational read
    assign mem_rd_data = mem[mem_addr[9:2]];

    // image reloaded while reset is held
    always @(posedge clk) begin
        if (rst) begin
            mem <= image;
        end else if (mem_wr_ena) begin
            mem[mem_addr[9:2]] <= mem_wr_data;
        end
    end

    // instruction encoders
    function automatic instr_t r_type(funct7_t f7, reg_addr_t rs2, reg_addr_t rs1,
                                      funct3_t f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t i_type(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                      reg_addr_t rd, opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    function automatic instr_t b_type(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                      funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic instr_t j_type(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(input instr_t ins);
        image[emit_idx] = ins;
        emit_idx++;
    endtask

    // store a register to the next free result word
    task automatic add_store(input reg_addr_t src);
        emit(s_type(st_off, src, X0));
        st_off = st_off + 12'd4;
    endtask

    // taken branch skips the x10 increment behind it
    task automatic add_branch(input funct3_t f3, input reg_addr_t rs1, input reg_addr_t rs2);
        emit(b_type(13'd8, rs2, rs1, f3));
        emit(i_type(12'd1, X10, F3_ADD_SUB, X10, OPC_OP_IMM));
    endtask

    task automatic build_program();
        funct3_t f3;
        funct3_t br [6];
        word_t   rnd;
        word_t   tgt;
        // background differs at every address
        for (int i = 0; i < 256; i++) begin
            image[i] = ~word_t'(i * 4);
        end
        // operands at 0x200, x1 negative and x2 positive
        image[128] = $random(seed) | 32'h8000_0000;
        image[129] = $random(seed) & 32'h7fff_ffff;
        image[130] = $random(seed);
        emit_idx = 0;
        st_off   = 12'h300;
        emit(i_type(12'h200, X0, F3_WORD, X1, OPC_LOAD));
        emit(i_type(12'h204, X0, F3_WORD, X2, OPC_LOAD));
        emit(i_type(12'h208, X0, F3_WORD, X3, OPC_LOAD));
        add_store(X3);
        // each alu funct3 in register and immediate form
        for (int f = 0; f < 8; f++) begin
            f3  = funct3_t'(f);
            rnd = $random(seed);
            emit(r_type(7'd0, X2, X1, f3, X5));
            add_store(X5);
            if (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) begin
                emit(r_type(F7_ALT, X2, X1, f3, X5));
                add_store(X5);
            end
            if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
                emit(i_type({7'd0, rnd[4:0]}, X1, f3, X6, OPC_OP_IMM));
            end else begin
                emit(i_type(rnd[11:0], X1, f3, X6, OPC_OP_IMM));
            end
            add_store(X6);
            if (f3 == F3_SRL_SRA) begin
                emit(i_type({F7_ALT, rnd[4:0]}, X1, f3, X6, OPC_OP_IMM));
                add_store(X6);
            end
        end
        // x0 ignores writes
        emit(i_type(12'd5, X1, F3_ADD_SUB, X0, OPC_OP_IMM));
        add_store(X0);
        // x4 equals x1 for the equal-operand branches
        emit(i_type(12'd0, X1, F3_ADD_SUB, X4, OPC_OP_IMM));
        br = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int k = 0; k < 6; k++) begin
            add_branch(br[k], X1, X2);
            add_branch(br[k], X2, X1);
            add_branch(br[k], X1, X4);
        end
        add_store(X10);
        emit(j_type(21'd8, X7));
        emit(i_type(12'd1, X10, F3_ADD_SUB, X10, OPC_OP_IMM));
        add_store(X7);
        // jalr through x9, which points past the skipped slot
        tgt = word_t'(emit_idx * 4 + 12);
        emit(i_type(tgt[11:0], X0, F3_ADD_SUB, X9, OPC_OP_IMM));
        emit(i_type(12'd0, X9, F3_JALR, X8, OPC_JALR));
        emit(i_type(12'd1, X10, F3_ADD_SUB, X10, OPC_OP_IMM));
        add_store(X8);
        add_store(X10);
        // jump to self ends the program
        halt_addr = word_t'(emit_idx * 4);
        emit(j_type(21'd0, X0));
        prog_len = emit_idx;
    endtask

    // ISA model, one instruction per call
    function automatic void step_model(output word_t next_pc, output logic st_ena,
                                       output word_t st_addr, output word_t st_data,
                                       output int cycles);
        instr_t    ins;
        opcode_t   opc;
        funct3_t   f3;
        reg_addr_t rd;
        word_t     a;
        word_t     b;
        word_t     opb;
        word_t     imm_i;
        word_t     imm_s;
        word_t     imm_b;
        word_t     imm_j;
        word_t     res;
        word_t     sra;
        word_t     addr;
        logic      alt;
        logic      take;
        logic      wr;
        ins   = model_mem[model_pc[9:2]];
        opc   = ins[6:0];
        f3    = ins[14:12];
        rd    = ins[11:7];
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        next_pc = model_pc + 32'd4;
        st_ena  = 1'b0;
        st_addr = '0;
        st_data = '0;
        wr      = 1'b0;
        res     = '0;
        case (opc)
            OPC_OP, OPC_OP_IMM: begin
                cycles = 4;
                wr     = 1'b1;
                opb    = (opc == OPC_OP) ? b : imm_i;
                // bit 30 picks sub only in register form, sra in both
                alt    = ins[30] && (opc == OPC_OP || f3 == 3'b101);
                sra    = $signed(a) >>> opb[4:0];
                case (f3)
                    3'b000:  res = alt ? a - opb : a + opb;
                    3'b001:  res = a << opb[4:0];
                    3'b010:  res = {31'd0, $signed(a) < $signed(opb)};
                    3'b011:  res = {31'd0, a < opb};
                    3'b100:  res = a ^ opb;
                    3'b101:  res = alt ? sra : a >> opb[4:0];
                    3'b110:  res = a | opb;
                    default: res = a & opb;
                endcase
            end
            OPC_LOAD: begin
                cycles = 5;
                wr     = 1'b1;
                addr   = a + imm_i;
                res    = model_mem[addr[9:2]];
            end
            OPC_STORE: begin
                cycles  = 4;
                st_ena  = 1'b1;
                st_addr = a + imm_s;
                st_data = b;
                model_mem[st_addr[9:2]] = b;
            end
            OPC_BRANCH: begin
                cycles = 3;
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    default: take = (a >= b);
                endcase
                if (take) begin
                    next_pc = model_pc + imm_b;
                end
            end
            OPC_JAL: begin
                cycles  = 3;
                wr      = 1'b1;
                res     = model_pc + 32'd4;
                next_pc = model_pc + imm_j;
            end
            OPC_JALR: begin
                cycles  = 4;
                wr      = 1'b1;
                res     = model_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            default: begin
                // unknown opcode retires in two cycles and changes nothing
                cycles  = 2;
                next_pc = model_pc;
            end
        endcase
        if (wr && rd != X0) begin
            model_regs[rd] = res;
        end
        model_pc = next_pc;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // compare on every retire, outputs sampled at the falling edge
    initial begin : compare_proc
        word_t exp_pc;
        logic  exp_st;
        word_t exp_addr;
        word_t exp_data;
        int    exp_cycles;
        int    cycles;
        word_t retired;
        logic  finished;
        @(negedge rst);
        model_mem = image;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc = 32'd0;
        cycles   = 0;
        retired  = '0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            cycles++;
            if (instruction_done) begin
                step_model(exp_pc, exp_st, exp_addr, exp_data, exp_cycles);
                retired = retired + 32'd1;
                check_value("cycles", cycles, exp_cycles);
                check_value("mem_wr_ena", word_t'(mem_wr_ena), word_t'(exp_st));
                if (exp_st) begin
                    check_value("mem_addr", mem_addr, exp_addr);
                    check_value("mem_wr_data", mem_wr_data, exp_data);
                end
                // pc and count settle on the closing edge
                @(negedge clk);
                cycles = 1;
                check_value("pc", pc, exp_pc);
                check_value("instructions_completed", instructions_completed, retired);
                finished = (exp_pc == halt_addr);
            end
        end
        checks_done = 1'b1;
    end

    // bound by five cycles per program word, each runs at most once
    initial begin : watchdog
        wait (prog_len > 0);
        repeat (prog_len * 5 + 40) @(posedge clk);
        $display("ERROR: timeout, the core stalled before reaching the end of the program");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst  = 1'b1;
        seed = 5;
        build_program();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        wait (checks_done);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv32_mini_core.f */
hdl/rv32_isa_pkg.sv
hdl/core_ctrl_pkg.sv
hdl/core_ctrl_if.sv
hdl/alu.sv
hdl/register_file.sv
hdl/core_control.sv
hdl/core_datapath.sv
hdl/rv32_mini_core.sv
verif/core_properties.sv
verif/tb_rv32_mini_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rv32_mini_core
FILELIST  ?= rv32_mini_core.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
